// File: logic/csi2_pkt_pkg.sv
`default_nettype none

package csi2_pkt_pkg;

  // Leader byte that precedes every packet on the merged lane stream.
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  // Header field widths.
  localparam int DT_W = 6;
  localparam int VC_W = 2;
  localparam int WC_W = 16;

  // Field positions inside the header word.
  localparam int DT_LSB = 0;
  localparam int VC_LSB = 6;
  localparam int WC_LSB = 8;

  // Data types up to here are short packets and carry no payload.
  localparam logic [DT_W-1:0] SHORT_DT_MAX = 6'h0F;

  // Header bits covered by the ECC.
  localparam int HDR_W = DT_W + VC_W + WC_W;

endpackage

`default_nettype wire

// File: logic/csi2_ecc_pkg.sv
`default_nettype none

package csi2_ecc_pkg;

  localparam int ECC_W   = 6;
  localparam int ECC_LSB = 24;

  // Marks a syndrome that points at no single data bit.
  localparam logic [4:0] NO_POS = 5'h1F;

  // Data bits that feed each parity bit.
  localparam logic [23:0] ECC_MASK [ECC_W] = '{
    24'hF12CB7,
    24'hF2555B,
    24'h749A6D,
    24'hB8E38E,
    24'hDF03F0,
    24'hEFFC00
  };

  function automatic logic [ECC_W-1:0] ecc_parity(input logic [23:0] hdr);
    logic [ECC_W-1:0] par;
    for (int k = 0; k < ECC_W; k++)
    begin
      par[k] = ^(hdr & ECC_MASK[k]);
    end
    return par;
  endfunction

  // A single flipped data bit gives a syndrome equal to that bit's column.
  function automatic logic [4:0] ecc_err_pos(input logic [ECC_W-1:0] syn);
    logic [4:0] pos;
    pos = NO_POS;
    for (int i = 0; i < 24; i++)
    begin
      if (ecc_parity(24'd1 << i) == syn)
        pos = 5'(i);
    end
    return pos;
  endfunction

endpackage

`default_nettype wire

// File: logic/csi2_sync_packer.sv
`default_nettype none

module csi2_sync_packer
  import csi2_pkt_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [7:0]  byte_i,
  input  logic        byte_valid_i,
  input  logic        pkt_done_i,
  output logic [31:0] word_o,
  output logic        word_valid_o
);

  typedef enum logic {HUNT, PACK} state_t;

  state_t      state;
  logic [1:0]  byte_cnt;
  logic [23:0] shift_q;

  // Partial words are never flushed, the sender pads to a word boundary.
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state        <= HUNT;
      byte_cnt     <= 2'd0;
      word_valid_o <= 1'b0;
    end
    else
    begin
      word_valid_o <= 1'b0;
      if (pkt_done_i)
      begin
        state    <= HUNT;
        byte_cnt <= 2'd0;
      end
      else if (byte_valid_i)
      begin
        unique case (state)
          HUNT:
          begin
            if (byte_i == SYNC_BYTE)
              state <= PACK;
            byte_cnt <= 2'd0;
          end
          PACK:
          begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3)
              word_valid_o <= 1'b1;
          end
        endcase
      end
    end
  end

  // First byte of a word lands in bits 7:0.
  always_ff @(posedge clk_i)
  begin
    if (byte_valid_i && state == PACK)
    begin
      shift_q <= {byte_i, shift_q[23:8]};
      if (byte_cnt == 2'd3)
        word_o <= {byte_i, shift_q};
    end
  end

endmodule

`default_nettype wire

// File: logic/csi2_hamming_dec.sv
`default_nettype none

module csi2_hamming_dec
  import csi2_ecc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        valid_i,
  input  logic [31:0] data_i,
  input  logic        pkt_done_i,
  output logic        error_o,
  output logic        error_corrected_o,
  output logic [31:0] data_o,
  output logic        valid_o
);

  logic [31:0]      data_d;
  logic             valid_d;
  logic             header_passed;
  logic             header_valid;
  logic [ECC_W-1:0] syndrome;
  logic             error_detected;
  logic [4:0]       err_bit_pos;
  logic             fix_bit;

  // Only the first word after a packet end is a header.
  assign header_valid   = valid_d && !header_passed;
  assign syndrome       = ecc_parity(data_d[23:0]) ^ data_d[ECC_LSB +: ECC_W];
  assign error_detected = (syndrome != '0);
  assign err_bit_pos    = ecc_err_pos(syndrome);
  assign fix_bit        = header_valid && error_detected && (err_bit_pos != NO_POS);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_d <= 1'b0;
    else
      valid_d <= valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    data_d <= data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      header_passed <= 1'b0;
    else if (pkt_done_i)
      header_passed <= 1'b0;
    else if (header_valid)
      header_passed <= 1'b1;
  end

  // Flags stay up for the rest of the packet.
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else if (pkt_done_i)
    begin
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else
    begin
      if (header_valid && error_detected)
        error_o <= 1'b1;
      if (fix_bit)
        error_corrected_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fix_bit)
      data_o <= data_d ^ (32'd1 << err_bit_pos);
    else
      data_o <= data_d;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_o <= 1'b0;
    else
      valid_o <= valid_d;
  end

endmodule

`default_nettype wire

// File: logic/csi2_pkt_parser.sv
`default_nettype none

module csi2_pkt_parser
  import csi2_pkt_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [31:0]     data_i,
  input  logic            valid_i,
  input  logic            err_i,
  input  logic            corrected_i,
  output logic [DT_W-1:0] dt_o,
  output logic [VC_W-1:0] vc_o,
  output logic [WC_W-1:0] wc_o,
  output logic            hdr_valid_o,
  output logic            hdr_err_o,
  output logic            hdr_corrected_o,
  output logic [31:0]     payload_o,
  output logic            payload_valid_o,
  output logic            pkt_done_o
);

  logic [HDR_W-1:0] hdr;
  logic             expect_hdr;
  logic             is_short;
  logic             drop;
  logic [WC_W:0]    wc_pad;
  logic [WC_W-1:0]  words_left;

  assign hdr      = data_i[HDR_W-1:0];
  assign is_short = (hdr[DT_LSB +: DT_W] <= SHORT_DT_MAX);
  assign drop     = err_i && !corrected_i;
  // Payload plus two CRC bytes, rounded up to whole words.
  assign wc_pad   = {1'b0, hdr[WC_LSB +: WC_W]} + (WC_W + 1)'(5);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      expect_hdr      <= 1'b1;
      words_left      <= '0;
      hdr_valid_o     <= 1'b0;
      hdr_err_o       <= 1'b0;
      hdr_corrected_o <= 1'b0;
      payload_valid_o <= 1'b0;
      pkt_done_o      <= 1'b0;
    end
    else
    begin
      hdr_valid_o     <= 1'b0;
      payload_valid_o <= 1'b0;
      pkt_done_o      <= 1'b0;
      if (valid_i && expect_hdr)
      begin
        hdr_valid_o     <= 1'b1;
        hdr_err_o       <= err_i;
        hdr_corrected_o <= corrected_i;
        if (drop || is_short)
          pkt_done_o <= 1'b1;
        else
        begin
          expect_hdr <= 1'b0;
          words_left <= {1'b0, wc_pad[WC_W:2]};
        end
      end
      else if (valid_i)
      begin
        payload_valid_o <= 1'b1;
        words_left      <= words_left - WC_W'(1);
        if (words_left == 1)
        begin
          pkt_done_o <= 1'b1;
          expect_hdr <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (valid_i && expect_hdr)
    begin
      dt_o <= hdr[DT_LSB +: DT_W];
      vc_o <= hdr[VC_LSB +: VC_W];
      wc_o <= hdr[WC_LSB +: WC_W];
    end
    if (valid_i && !expect_hdr)
      payload_o <= data_i;
  end

endmodule

`default_nettype wire

// File: logic/csi2_rx_top.sv
`default_nettype none

module csi2_rx_top
  import csi2_pkt_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [7:0]      byte_i,
  input  logic            byte_valid_i,
  output logic [DT_W-1:0] dt_o,
  output logic [VC_W-1:0] vc_o,
  output logic [WC_W-1:0] wc_o,
  output logic            hdr_valid_o,
  output logic            hdr_err_o,
  output logic            hdr_corrected_o,
  output logic [31:0]     payload_o,
  output logic            payload_valid_o,
  output logic            pkt_done_o
);

  logic [31:0] word;
  logic        word_valid;
  logic [31:0] dec_data;
  logic        dec_valid;
  logic        dec_err;
  logic        dec_corrected;
  logic        pkt_done;

  // End of packet rearms both the packer and the decoder.
  assign pkt_done_o = pkt_done;

  csi2_sync_packer u_packer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .byte_i       (byte_i),
    .byte_valid_i (byte_valid_i),
    .pkt_done_i   (pkt_done),
    .word_o       (word),
    .word_valid_o (word_valid)
  );

  csi2_hamming_dec u_dec (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .valid_i           (word_valid),
    .data_i            (word),
    .pkt_done_i        (pkt_done),
    .error_o           (dec_err),
    .error_corrected_o (dec_corrected),
    .data_o            (dec_data),
    .valid_o           (dec_valid)
  );

  csi2_pkt_parser u_parser (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .data_i          (dec_data),
    .valid_i         (dec_valid),
    .err_i           (dec_err),
    .corrected_i     (dec_corrected),
    .dt_o            (dt_o),
    .vc_o            (vc_o),
    .wc_o            (wc_o),
    .hdr_valid_o     (hdr_valid_o),
    .hdr_err_o       (hdr_err_o),
    .hdr_corrected_o (hdr_corrected_o),
    .payload_o       (payload_o),
    .payload_valid_o (payload_valid_o),
    .pkt_done_o      (pkt_done)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // Free running clock with a period of 4.
  initial
  begin
    clk_o = 1'b0;
    forever
      #2 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: sim/csi2_rx_chk.sv
`default_nettype none

module csi2_rx_chk (
  input logic clk_i,
  input logic rst_i,
  input logic hdr_valid_i,
  input logic hdr_err_i,
  input logic hdr_corrected_i,
  input logic payload_valid_i,
  input logic pkt_done_i
);

  // A corrected header is always also an errored header.
  corrected_implies_err: assert property (@(posedge clk_i) disable iff (rst_i)
    hdr_corrected_i |-> hdr_err_i)
    else $error("Header flagged corrected without the error flag");

  // Packet end rides on a header or on the last payload word.
  done_with_beat: assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_done_i |-> (hdr_valid_i || payload_valid_i))
    else $error("Packet end without a header or payload word");

  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |=> !(hdr_valid_i || payload_valid_i || pkt_done_i))
    else $error("Valid output seen while reset is held");

endmodule

bind csi2_rx_top csi2_rx_chk u_chk (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .hdr_valid_i     (hdr_valid_o),
  .hdr_err_i       (hdr_err_o),
  .hdr_corrected_i (hdr_corrected_o),
  .payload_valid_i (payload_valid_o),
  .pkt_done_i      (pkt_done_o)
);

`default_nettype wire

// File: sim/csi2_rx_tb.sv
`default_nettype none

module csi2_rx_tb
  import csi2_pkt_pkg::*;
  import csi2_ecc_pkg::*;
();

  logic            clk_i;
  logic            rst_i;
  logic [7:0]      byte_i;
  logic            byte_valid_i;
  logic [DT_W-1:0] dt_o;
  logic [VC_W-1:0] vc_o;
  logic [WC_W-1:0] wc_o;
  logic            hdr_valid_o;
  logic            hdr_err_o;
  logic            hdr_corrected_o;
  logic [31:0]     payload_o;
  logic            payload_valid_o;
  logic            pkt_done_o;

  logic [DT_W-1:0] pat_dt [$];
  logic [VC_W-1:0] pat_vc [$];
  logic [WC_W-1:0] pat_wc [$];
  logic [29:0]     pat_mask [$];

  // Filled by the monitor, read by the driver through its own indices.
  logic [DT_W-1:0] got_dt [$];
  logic [VC_W-1:0] got_vc [$];
  logic [WC_W-1:0] got_wc [$];
  logic            got_err [$];
  logic            got_corr [$];
  logic [31:0]     got_word [$];
  logic            got_done [$];
  int              hdr_rd;
  int              word_rd;
  int              done_rd;
  int              limit_cycles;
  logic [31:0]     rng;

  tb_clock_gen u_clk (.clk_o(clk_i));

  csi2_rx_top uut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .byte_i          (byte_i),
    .byte_valid_i    (byte_valid_i),
    .dt_o            (dt_o),
    .vc_o            (vc_o),
    .wc_o            (wc_o),
    .hdr_valid_o     (hdr_valid_o),
    .hdr_err_o       (hdr_err_o),
    .hdr_corrected_o (hdr_corrected_o),
    .payload_o       (payload_o),
    .payload_valid_o (payload_valid_o),
    .pkt_done_o      (pkt_done_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic header_error(input logic [29:0] mask);
    return mask != 30'd0;
  endfunction

  // Only a single flip inside the 24 data bits can be repaired.
  function automatic logic header_fixable(input logic [29:0] mask);
    return ($countones(mask) == 1) && (mask[29:24] == 6'd0);
  endfunction

  function automatic int expected_words(input logic [DT_W-1:0] dt, input logic [WC_W-1:0] wc,
                                        input logic [29:0] mask);
    if (dt <= SHORT_DT_MAX || (header_error(mask) && !header_fixable(mask)))
      return 0;
    return (int'(wc) + 2 + 3) / 4;
  endfunction

  function automatic logic [31:0] build_header(input logic [DT_W-1:0] dt,
                                               input logic [VC_W-1:0] vc,
                                               input logic [WC_W-1:0] wc,
                                               input logic [29:0] mask);
    logic [31:0] w;
    w = 32'd0;
    w[DT_LSB +: DT_W] = dt;
    w[VC_LSB +: VC_W] = vc;
    w[WC_LSB +: WC_W] = wc;
    w[ECC_LSB +: ECC_W] = ecc_parity(w[HDR_W-1:0]);
    return w ^ {2'b00, mask};
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_hdr(input string name, input logic fields_known, input int idx,
                           input logic [DT_W-1:0] exp_dt, input logic [VC_W-1:0] exp_vc,
                           input logic [WC_W-1:0] exp_wc, input logic exp_err,
                           input logic exp_corr);
    if (fields_known && got_dt[idx] !== exp_dt)
      report_failure($sformatf("ERR %s.dt expected %0h actual %0h", name, exp_dt, got_dt[idx]));
    if (fields_known && got_vc[idx] !== exp_vc)
      report_failure($sformatf("ERR %s.vc expected %0h actual %0h", name, exp_vc, got_vc[idx]));
    if (fields_known && got_wc[idx] !== exp_wc)
      report_failure($sformatf("ERR %s.wc expected %0h actual %0h", name, exp_wc, got_wc[idx]));
    if (got_err[idx] !== exp_err)
      report_failure($sformatf("ERR %s.err expected %0b actual %0b", name, exp_err, got_err[idx]));
    if (got_corr[idx] !== exp_corr)
      report_failure($sformatf("ERR %s.corrected expected %0b actual %0b", name, exp_corr,
                               got_corr[idx]));
  endtask

  task automatic check_word(input string name, input logic [31:0] exp_word,
                            input logic [31:0] act_word);
    if (act_word !== exp_word)
      report_failure($sformatf("ERR %s expected %08h actual %08h", name, exp_word, act_word));
  endtask

  task automatic check_done(input string name, input int exp_words, input int act_words,
                            input logic exp_with_hdr, input logic act_with_hdr);
    if (act_words != exp_words)
      report_failure($sformatf("ERR %s.words expected %0d actual %0d", name, exp_words,
                               act_words));
    if (act_with_hdr !== exp_with_hdr)
      report_failure($sformatf("ERR %s.done_with_hdr expected %0b actual %0b", name,
                               exp_with_hdr, act_with_hdr));
  endtask

  always @(negedge clk_i)
  begin
    if (hdr_valid_o)
    begin
      got_dt.push_back(dt_o);
      got_vc.push_back(vc_o);
      got_wc.push_back(wc_o);
      got_err.push_back(hdr_err_o);
      got_corr.push_back(hdr_corrected_o);
    end
    if (payload_valid_o)
      got_word.push_back(payload_o);
    if (pkt_done_o)
      got_done.push_back(hdr_valid_o);
  end

  // Random idle gap of zero to two cycles before each byte.
  task automatic send_byte(input logic [7:0] b);
    int gap;
    rng = xorshift32(rng);
    gap = int'(rng % 32'd3);
    repeat (gap)
    begin
      @(posedge clk_i);
      byte_valid_i <= 1'b0;
    end
    @(posedge clk_i);
    byte_i       <= b;
    byte_valid_i <= 1'b1;
  endtask

  task automatic send_idle_byte();
    logic [7:0] b;
    rng = xorshift32(rng);
    b = rng[15:8];
    if (b == SYNC_BYTE)
      b = ~b;
    send_byte(b);
  endtask

  task automatic stop_bytes();
    @(posedge clk_i);
    byte_valid_i <= 1'b0;
  endtask

  task automatic run_packet(input int idx);
    logic [31:0] hdr_word;
    logic [7:0]  pay [$];
    logic        no_payload;
    int          n_words;
    string       name;
    name       = $sformatf("pkt%0d", idx);
    n_words    = expected_words(pat_dt[idx], pat_wc[idx], pat_mask[idx]);
    no_payload = (n_words == 0);
    hdr_word   = build_header(pat_dt[idx], pat_vc[idx], pat_wc[idx], pat_mask[idx]);
    send_byte(SYNC_BYTE);
    for (int i = 0; i < 4; i++)
      send_byte(hdr_word[8*i +: 8]);
    for (int i = 0; i < 4 * n_words; i++)
    begin
      rng = xorshift32(rng);
      pay.push_back(rng[7:0]);
      send_byte(rng[7:0]);
    end
    stop_bytes();
    while (got_done.size() <= done_rd)
      @(posedge clk_i);
    if (got_dt.size() != hdr_rd + 1)
      report_failure($sformatf("%s gave %0d headers where one was due", name,
                               got_dt.size() - hdr_rd));
    check_hdr(name, !(header_error(pat_mask[idx]) && !header_fixable(pat_mask[idx])), hdr_rd,
              pat_dt[idx], pat_vc[idx], pat_wc[idx], header_error(pat_mask[idx]),
              header_fixable(pat_mask[idx]));
    check_done(name, n_words, got_word.size() - word_rd, no_payload, got_done[done_rd]);
    for (int k = 0; k < n_words; k++)
      check_word($sformatf("%s.word%0d", name, k),
                 {pay[4*k+3], pay[4*k+2], pay[4*k+1], pay[4*k]}, got_word[word_rd + k]);
    hdr_rd  = hdr_rd + 1;
    done_rd = done_rd + 1;
    word_rd = word_rd + n_words;
    // Non-sync filler between packets.
    for (int i = 0; i < 3; i++)
      send_idle_byte();
  endtask

  task automatic reset_mid_packet();
    logic [31:0] hdr_word;
    hdr_word = build_header(6'h2A, 2'd1, 16'd16, 30'd0);
    send_byte(SYNC_BYTE);
    for (int i = 0; i < 4; i++)
      send_byte(hdr_word[8*i +: 8]);
    for (int i = 0; i < 6; i++)
      send_idle_byte();
    @(posedge clk_i);
    rst_i        <= 1'b1;
    byte_valid_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    hdr_rd  = got_dt.size();
    word_rd = got_word.size();
    done_rd = got_done.size();
    for (int i = 0; i < 6; i++)
      send_idle_byte();
    stop_bytes();
    repeat (8) @(posedge clk_i);
    if (got_dt.size() != hdr_rd || got_word.size() != word_rd || got_done.size() != done_rd)
      report_failure("An output strobe fired after reset before any sync byte was sent");
  endtask

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    report_failure($sformatf("Timeout after %0d cycles, the DUT never ended a packet",
                             limit_cycles));
  end

  initial
  begin
    string       line;
    int          fd;
    int          n;
    int          total_bytes;
    logic [31:0] f_dt;
    logic [31:0] f_vc;
    logic [31:0] f_wc;
    logic [31:0] f_mask;
    rst_i        = 1'b1;
    byte_i       = 8'h00;
    byte_valid_i = 1'b0;
    rng          = 32'd4066;
    limit_cycles = 0;
    hdr_rd       = 0;
    word_rd      = 0;
    done_rd      = 0;
    fd = $fopen("sim/csi2_rx_patterns.txt", "r");
    if (fd == 0)
      report_failure("Could not open sim/csi2_rx_patterns.txt");
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#" && $sscanf(line, "%h %h %h %h", f_dt, f_vc, f_wc, f_mask) == 4)
      begin
        pat_dt.push_back(f_dt[DT_W-1:0]);
        pat_vc.push_back(f_vc[VC_W-1:0]);
        pat_wc.push_back(f_wc[WC_W-1:0]);
        pat_mask.push_back(f_mask[29:0]);
      end
    end
    $fclose(fd);
    // Reset test sends 17 bytes, each packet sync, header and filler plus payload.
    total_bytes = 17;
    foreach (pat_dt[i])
      total_bytes += 8 + 4 * expected_words(pat_dt[i], pat_wc[i], pat_mask[i]);
    limit_cycles = 8 * total_bytes + 100;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (pat_dt[i])
    begin
      if (i == 6)
        reset_mid_packet();
      run_packet(i);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/csi2_rx_patterns.txt
# dt vc wc err_mask, all hex, one packet per line
# err_mask bits 23:0 flip header data bits, bits 29:24 flip ECC bits
2a 0 0010 00000000
2b 1 0007 00000000
1e 2 0001 00000000
2a 1 000c 00000010
2c 3 0005 00800000
24 0 0003 00000101
12 3 0000 00000000
00 0 1234 00000000
2a 0 0008 20000000
01 2 0001 00000000
08 1 0000 00040000
2b 2 0020 00000000
22 0 0004 00c00000
2d 1 0002 00000000

// File: verilog.f
logic/csi2_pkt_pkg.sv
logic/csi2_ecc_pkg.sv
logic/csi2_sync_packer.sv
logic/csi2_hamming_dec.sv
logic/csi2_pkt_parser.sv
logic/csi2_rx_top.sv
sim/tb_clock_gen.sv
sim/csi2_rx_chk.sv
sim/csi2_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the CSI-2 header stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module csi2_rx_tb \
  -Mdir obj_dir -o csi2_rx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csi2_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  echo "Simulation PASS"
  exit 0
fi
echo "Simulation FAIL"
exit 1
